/* build.f */
+incdir+verification
source/rdma_pkg.sv
source/req_queue.sv
source/req_dispatch.sv
source/write_segmenter.sv
source/single_packet_encoder.sv
source/packet_merger.sv
source/rdma_req_parser.sv
verification/tb_rdma_req_parser.sv

/* source/packet_merger.sv */
module packet_merger (
  input  logic               aclk,
  input  logic               aresetn,
  // From write segmenter
  input  logic               wr_valid,
  output logic               wr_ready,
  input  rdma_pkg::pkt_req_t wr_data,
  // From single packet encoder
  input  logic               sp_valid,
  output logic               sp_ready,
  input  rdma_pkg::pkt_req_t sp_data,
  // Merged stream to output queue
  output logic               out_valid,
  input  logic               out_ready,
  output rdma_pkg::pkt_req_t out_data
);

  rdma_pkg::mrg_state_t last_src;  // Last granted source
  rdma_pkg::mrg_state_t grant;
  logic                 lock;      // Output stalled, keep grant

  always_comb begin
    if (lock) begin
      grant = last_src;
    end else if (wr_valid && sp_valid) begin  // Contention, alternate
      grant = (last_src == rdma_pkg::SRC_WR) ? rdma_pkg::SRC_SP : rdma_pkg::SRC_WR;
    end else if (wr_valid) begin
      grant = rdma_pkg::SRC_WR;
    end else begin
      grant = rdma_pkg::SRC_SP;
    end
  end

  assign out_valid = (grant == rdma_pkg::SRC_WR) ? wr_valid : sp_valid;
  assign out_data  = (grant == rdma_pkg::SRC_WR) ? wr_data  : sp_data;
  assign wr_ready  = out_ready && (grant == rdma_pkg::SRC_WR);
  assign sp_ready  = out_ready && (grant == rdma_pkg::SRC_SP);

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      last_src <= rdma_pkg::SRC_SP;  // First tie goes to writes
      lock     <= 1'b0;
    end else if (out_valid) begin
      last_src <= grant;
      lock     <= !out_ready;        // Hold until taken
    end
  end

  // Engines hold their word and the grant holds the source
  assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("packet_merger: output changed while stalled");

endmodule

/* source/rdma_pkg.sv */
package rdma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [4:0]  opcode_t;  // App or RC opcode
  typedef logic [9:0]  qpn_t;     // Queue pair number
  typedef logic [47:0] vaddr_t;   // Virtual address
  typedef logic [31:0] len_t;     // Byte length
  typedef logic [15:0] params_t;  // Opaque, carried through untouched

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam len_t PMTU_BYTES  = 32'd1024;  // Segment size for writes
  localparam int   QUEUE_DEPTH = 16;        // Default decoupling depth

  // Application opcodes
  localparam opcode_t APP_READ  = 5'd1;
  localparam opcode_t APP_WRITE = 5'd2;
  localparam opcode_t APP_SEND  = 5'd3;
  localparam opcode_t APP_IMMED = 5'd4;

  // RC opcodes on the wire
  localparam opcode_t RC_SEND_ONLY         = 5'd4;
  localparam opcode_t RC_RDMA_WRITE_FIRST  = 5'd6;
  localparam opcode_t RC_RDMA_WRITE_MIDDLE = 5'd7;
  localparam opcode_t RC_RDMA_WRITE_LAST   = 5'd8;
  localparam opcode_t RC_RDMA_WRITE_ONLY   = 5'd10;
  localparam opcode_t RC_RDMA_READ_REQUEST = 5'd12;

  //////////////////////////////////////////////////////////////////////
  // Request and packet words
  //////////////////////////////////////////////////////////////////////

  // Application request as posted by software
  typedef struct packed {
    opcode_t opcode;
    qpn_t    qpn;
    logic    mode;    // 1 = raw, opcode passed as is
    vaddr_t  lvaddr;
    vaddr_t  rvaddr;
    len_t    len;
    params_t params;
  } app_req_t;

  // One RC request packet
  typedef struct packed {
    opcode_t opcode;
    qpn_t    qpn;
    logic    host;    // 0 only for immediates
    logic    mode;
    logic    last;
    vaddr_t  lvaddr;
    vaddr_t  rvaddr;
    len_t    len;
    params_t params;
  } pkt_req_t;

  // Merger bookkeeping, which engine was granted last
  typedef enum logic {
    SRC_WR,
    SRC_SP
  } mrg_state_t;

endpackage

/* source/rdma_req_parser.sv */
module rdma_req_parser (
  input  logic               aclk,
  input  logic               aresetn,
  // Application requests
  input  logic               req_valid,
  output logic               req_ready,
  input  rdma_pkg::app_req_t req_data,
  // RC request packets
  output logic               pkt_valid,
  input  logic               pkt_ready,
  output rdma_pkg::pkt_req_t pkt_data,
  // Input queue fill level
  output logic [31:0]        used
);

  //////////////////////////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////////////////////////

  logic               q_valid,  q_ready;   // Input queue to dispatch
  rdma_pkg::app_req_t q_data;
  logic               wr_req_valid, wr_req_ready;
  rdma_pkg::app_req_t wr_req_data;
  logic               sp_req_valid, sp_req_ready;
  rdma_pkg::app_req_t sp_req_data;
  logic               wr_pkt_valid, wr_pkt_ready;
  rdma_pkg::pkt_req_t wr_pkt_data;
  logic               sp_pkt_valid, sp_pkt_ready;
  rdma_pkg::pkt_req_t sp_pkt_data;
  logic               m_valid,  m_ready;   // Merger to output queue
  rdma_pkg::pkt_req_t m_data;

  req_queue #(.DEPTH(rdma_pkg::QUEUE_DEPTH), .T(rdma_pkg::app_req_t)) inst_queue_in (
    .aclk, .aresetn,
    .in_valid(req_valid), .in_ready(req_ready), .in_data(req_data),
    .out_valid(q_valid),  .out_ready(q_ready),  .out_data(q_data),
    .count(used)
  );

  req_dispatch inst_dispatch (
    .in_valid(q_valid),     .in_ready(q_ready),     .in_data(q_data),
    .wr_valid(wr_req_valid), .wr_ready(wr_req_ready), .wr_data(wr_req_data),
    .sp_valid(sp_req_valid), .sp_ready(sp_req_ready), .sp_data(sp_req_data)
  );

  write_segmenter inst_write_seg (
    .aclk, .aresetn,
    .in_valid(wr_req_valid),  .in_ready(wr_req_ready),  .in_data(wr_req_data),
    .out_valid(wr_pkt_valid), .out_ready(wr_pkt_ready), .out_data(wr_pkt_data)
  );

  single_packet_encoder inst_sp_enc (
    .aclk, .aresetn,
    .in_valid(sp_req_valid),  .in_ready(sp_req_ready),  .in_data(sp_req_data),
    .out_valid(sp_pkt_valid), .out_ready(sp_pkt_ready), .out_data(sp_pkt_data)
  );

  packet_merger inst_merger (
    .aclk, .aresetn,
    .wr_valid(wr_pkt_valid), .wr_ready(wr_pkt_ready), .wr_data(wr_pkt_data),
    .sp_valid(sp_pkt_valid), .sp_ready(sp_pkt_ready), .sp_data(sp_pkt_data),
    .out_valid(m_valid),     .out_ready(m_ready),     .out_data(m_data)
  );

  // Only the input level is exported
  req_queue #(.DEPTH(rdma_pkg::QUEUE_DEPTH), .T(rdma_pkg::pkt_req_t)) inst_queue_out (
    .aclk, .aresetn,
    .in_valid(m_valid),    .in_ready(m_ready),    .in_data(m_data),
    .out_valid(pkt_valid), .out_ready(pkt_ready), .out_data(pkt_data),
    .count()
  );

endmodule

/* source/req_dispatch.sv */
module req_dispatch (
  // From input queue
  input  logic               in_valid,
  output logic               in_ready,
  input  rdma_pkg::app_req_t in_data,
  // To write segmenter
  output logic               wr_valid,
  input  logic               wr_ready,
  output rdma_pkg::app_req_t wr_data,
  // To single packet encoder
  output logic               sp_valid,
  input  logic               sp_ready,
  output rdma_pkg::app_req_t sp_data
);

  logic is_wr;  // Non-raw write
  logic is_sp;  // Raw, or read / send / immediate

  always_comb begin
    is_wr = !in_data.mode && (in_data.opcode == rdma_pkg::APP_WRITE);
    is_sp = in_data.mode ||
            (in_data.opcode == rdma_pkg::APP_READ) ||
            (in_data.opcode == rdma_pkg::APP_SEND) ||
            (in_data.opcode == rdma_pkg::APP_IMMED);
  end

  // Same word to both engines, valid only toward the chosen one
  assign wr_data  = in_data;
  assign sp_data  = in_data;
  assign wr_valid = in_valid & is_wr;
  assign sp_valid = in_valid & is_sp;

  // Unknown non-raw opcode is acked and dropped
  assign in_ready = is_wr ? wr_ready :
                    is_sp ? sp_ready : 1'b1;

  // Decode keeps the two routes disjoint
  always_comb begin
    assert #0 (!(wr_valid && sp_valid))
      else $error("req_dispatch: request routed to both engines");
  end

endmodule

/* source/req_queue.sv */
module req_queue #(
  parameter int  DEPTH = rdma_pkg::QUEUE_DEPTH,
  parameter type T     = rdma_pkg::app_req_t
) (
  input  logic        aclk,
  input  logic        aresetn,
  // Write side
  input  logic        in_valid,
  output logic        in_ready,
  input  T            in_data,
  // Read side
  output logic        out_valid,
  input  logic        out_ready,
  output T            out_data,
  // Fill level
  output logic [31:0] count
);

  T                         mem [DEPTH];  // Storage
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     wr_en;
  logic                     rd_en;

  assign in_ready  = (count != DEPTH);  // Low only when full
  assign out_valid = (count != 0);
  assign out_data  = mem[rd_ptr];       // Head word, stable until popped

  assign wr_en = in_valid & in_ready;
  assign rd_en = out_valid & out_ready;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;  // Wrap
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 32'd1;
        2'b01:   count <= count - 32'd1;
        default: ;  // Both or neither, level unchanged
      endcase
    end
  end

  // Full queue without a pop must not move the write pointer
  assert property (@(posedge aclk) disable iff (!aresetn)
    (count == DEPTH) && !rd_en |=> $stable(wr_ptr) && (count == DEPTH))
    else $error("req_queue: write accepted while full");

endmodule

/* source/single_packet_encoder.sv */
module single_packet_encoder (
  input  logic               aclk,
  input  logic               aresetn,
  // Read / send / immediate / raw requests
  input  logic               in_valid,
  output logic               in_ready,
  input  rdma_pkg::app_req_t in_data,
  // One RC packet per request
  output logic               out_valid,
  input  logic               out_ready,
  output rdma_pkg::pkt_req_t out_data
);

  rdma_pkg::pkt_req_t enc;  // Translated request, before the register

  //////////////////////////////////////////////////////////////////////
  // Opcode mapping
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    enc.opcode = in_data.opcode;  // Raw mode keeps it
    if (!in_data.mode) begin
      case (in_data.opcode)
        rdma_pkg::APP_READ:  enc.opcode = rdma_pkg::RC_RDMA_READ_REQUEST;
        rdma_pkg::APP_SEND,
        rdma_pkg::APP_IMMED: enc.opcode = rdma_pkg::RC_SEND_ONLY;
        default:             ;  // Filtered out by dispatch
      endcase
    end
    enc.qpn    = in_data.qpn;
    enc.host   = (in_data.opcode != rdma_pkg::APP_IMMED);
    enc.mode   = in_data.mode;
    enc.last   = 1'b1;            // Always a single packet
    enc.lvaddr = in_data.lvaddr;
    enc.rvaddr = in_data.rvaddr;
    enc.len    = in_data.len;
    enc.params = in_data.params;
  end

  // Output stage, refills in the same cycle it drains
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;                // Drained, nothing new
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin
      out_data <= enc;
    end
  end

endmodule

/* source/write_segmenter.sv */
module write_segmenter (
  input  logic               aclk,
  input  logic               aresetn,
  // Write requests from dispatch
  input  logic               in_valid,
  output logic               in_ready,
  input  rdma_pkg::app_req_t in_data,
  // Segmented RC packets
  output logic               out_valid,
  input  logic               out_ready,
  output rdma_pkg::pkt_req_t out_data
);

  typedef enum logic [1:0] {
    SEG_IDLE,   // Waiting for a write
    SEG_FIRST,  // First packet on the output
    SEG_NEXT    // Middle or last packet on the output
  } seg_state_t;

  seg_state_t        state;

  // Per-request fields, fixed for the whole write
  rdma_pkg::qpn_t    qpn_q;
  rdma_pkg::params_t params_q;
  logic              mode_q;

  // Running segment position
  rdma_pkg::len_t    rem_len;   // Bytes not yet sent
  rdma_pkg::vaddr_t  lvaddr_q;
  rdma_pkg::vaddr_t  rvaddr_q;

  logic              last_pkt;  // Remainder fits in one packet
  logic              pkt_take;

  assign last_pkt  = (rem_len <= rdma_pkg::PMTU_BYTES);
  assign in_ready  = (state == SEG_IDLE);
  assign out_valid = (state != SEG_IDLE);
  assign pkt_take  = out_valid & out_ready;

  //////////////////////////////////////////////////////////////////////
  // Packet build
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (state == SEG_FIRST) begin
      out_data.opcode = last_pkt ? rdma_pkg::RC_RDMA_WRITE_ONLY
                                 : rdma_pkg::RC_RDMA_WRITE_FIRST;
    end else begin
      out_data.opcode = last_pkt ? rdma_pkg::RC_RDMA_WRITE_LAST
                                 : rdma_pkg::RC_RDMA_WRITE_MIDDLE;
    end
    out_data.qpn    = qpn_q;
    out_data.host   = 1'b1;     // Writes always from host memory
    out_data.mode   = mode_q;
    out_data.last   = 1'b1;
    out_data.lvaddr = lvaddr_q;
    out_data.rvaddr = rvaddr_q;
    out_data.len    = last_pkt ? rem_len : rdma_pkg::PMTU_BYTES;  // Tail gets remainder
    out_data.params = params_q;
  end

  //////////////////////////////////////////////////////////////////////
  // FSM and segment registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state <= SEG_IDLE;
    end else begin
      case (state)
        SEG_IDLE: if (in_valid) state <= SEG_FIRST;
        default:  if (out_ready) state <= last_pkt ? SEG_IDLE : SEG_NEXT;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin  // Capture new write
      qpn_q    <= in_data.qpn;
      params_q <= in_data.params;
      mode_q   <= in_data.mode;
      rem_len  <= in_data.len;
      lvaddr_q <= in_data.lvaddr;
      rvaddr_q <= in_data.rvaddr;
    end else if (pkt_take && !last_pkt) begin  // Step to next segment
      rem_len  <= rem_len - rdma_pkg::PMTU_BYTES;
      lvaddr_q <= lvaddr_q + rdma_pkg::vaddr_t'(rdma_pkg::PMTU_BYTES);
      rvaddr_q <= rvaddr_q + rdma_pkg::vaddr_t'(rdma_pkg::PMTU_BYTES);
    end
  end

  assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid |-> out_data.len <= rdma_pkg::PMTU_BYTES)
    else $error("write_segmenter: packet longer than PMTU");

endmodule

/* verification/rdma_ref_model.svh */
`ifndef RDMA_REF_MODEL_SVH
`define RDMA_REF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model, expected packets per engine class
//////////////////////////////////////////////////////////////////////

rdma_pkg::pkt_req_t exp_wr [$];  // Non-raw write segments
rdma_pkg::pkt_req_t exp_sp [$];  // Everything from the single packet path

// Expand one accepted request into its packets
function automatic void predict(input rdma_pkg::app_req_t r);
  rdma_pkg::pkt_req_t p;
  rdma_pkg::len_t     rem;
  p.opcode = r.opcode;
  p.qpn    = r.qpn;
  p.host   = (r.opcode != rdma_pkg::APP_IMMED);  // Immediates only
  p.mode   = r.mode;
  p.last   = 1'b1;
  p.lvaddr = r.lvaddr;
  p.rvaddr = r.rvaddr;
  p.len    = r.len;
  p.params = r.params;
  if (r.mode) begin
    exp_sp.push_back(p);  // Raw, as is
  end else if (r.opcode == rdma_pkg::APP_READ) begin
    p.opcode = rdma_pkg::RC_RDMA_READ_REQUEST;
    exp_sp.push_back(p);
  end else if (r.opcode == rdma_pkg::APP_SEND || r.opcode == rdma_pkg::APP_IMMED) begin
    p.opcode = rdma_pkg::RC_SEND_ONLY;
    exp_sp.push_back(p);
  end else if (r.opcode == rdma_pkg::APP_WRITE) begin
    rem      = r.len;
    p.opcode = (rem <= rdma_pkg::PMTU_BYTES) ? rdma_pkg::RC_RDMA_WRITE_ONLY
                                             : rdma_pkg::RC_RDMA_WRITE_FIRST;
    // Full PMTU segments first
    while (rem > rdma_pkg::PMTU_BYTES) begin
      p.len = rdma_pkg::PMTU_BYTES;
      exp_wr.push_back(p);
      rem      = rem - rdma_pkg::PMTU_BYTES;
      p.lvaddr = p.lvaddr + rdma_pkg::vaddr_t'(rdma_pkg::PMTU_BYTES);
      p.rvaddr = p.rvaddr + rdma_pkg::vaddr_t'(rdma_pkg::PMTU_BYTES);
      p.opcode = (rem <= rdma_pkg::PMTU_BYTES) ? rdma_pkg::RC_RDMA_WRITE_LAST
                                               : rdma_pkg::RC_RDMA_WRITE_MIDDLE;
    end
    p.len = rem;  // Remainder
    exp_wr.push_back(p);
  end
  // Unknown non-raw opcode, no packet
endfunction

`endif

/* verification/tb_rdma_req_parser.sv */
module tb_rdma_req_parser;

  timeunit 1ns;
  timeprecision 1ps;

  logic               aclk;
  logic               aresetn;
  logic               req_valid;
  logic               req_ready;
  rdma_pkg::app_req_t req_data;
  logic               pkt_valid;
  logic               pkt_ready;
  rdma_pkg::pkt_req_t pkt_data;
  logic [31:0]        used;

  logic [31:0] lfsr = 32'h581ab98c;
  int          errors;
  int          npkt;      // Packets taken at the output
  int          rdy_mode;  // 0 always ready, 1 random with a stall window
  int          rdy_cyc;
  logic        rdy_next;  // Next pkt_ready value

  `include "rdma_ref_model.svh"

  rdma_req_parser dut (
    .aclk, .aresetn,
    .req_valid, .req_ready, .req_data,
    .pkt_valid, .pkt_ready, .pkt_data,
    .used
  );

  always #20 aclk = ~aclk;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic rdma_pkg::app_req_t make_req(input rdma_pkg::opcode_t op,
                                                  input logic mode,
                                                  input rdma_pkg::len_t len);
    rdma_pkg::app_req_t r;
    r.opcode = op;
    r.mode   = mode;
    r.len    = len;
    r.qpn    = 10'(rand_bits(10));
    r.lvaddr = {16'(rand_bits(16)), rand_bits(32)};
    r.rvaddr = {16'(rand_bits(16)), rand_bits(32)};
    r.params = 16'(rand_bits(16));
    return r;
  endfunction

  // Weighted toward writes, some raw and some unknown
  function automatic rdma_pkg::app_req_t rand_req();
    logic [2:0]     pick;
    rdma_pkg::len_t len;
    pick = 3'(rand_bits(3));
    len  = 1 + (rand_bits(12) % 3500);
    case (pick)
      3'd0:             return make_req(rdma_pkg::APP_READ, 1'b0, len);
      3'd1, 3'd2, 3'd7: return make_req(rdma_pkg::APP_WRITE, 1'b0, len);
      3'd3:             return make_req(rdma_pkg::APP_SEND, 1'b0, len);
      3'd4:             return make_req(rdma_pkg::APP_IMMED, 1'b0, len);
      3'd5:             return make_req(5'd20 + 5'(rand_bits(3)), 1'b0, len);  // Unknown
      default:          return make_req(5'(rand_bits(5)), 1'b1, len);          // Raw
    endcase
  endfunction

  // Called and returns at 2 ns after an edge
  task automatic send_req(input rdma_pkg::app_req_t r);
    int waited;
    waited    = 0;
    req_valid = 1'b1;
    req_data  = r;
    @(posedge aclk);
    while (!req_ready && waited < 1000) begin
      @(posedge aclk);
      waited++;
    end
    if (req_ready) begin
      predict(r);
    end else begin
      errors++;
      $display("Request not accepted within 1000 cycles at %0t ns", $time);
    end
    #2;
    req_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge aclk);
      #2;
    end
  endtask

  // Every expected packet seen, then a quiet tail for strays
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_wr.size() != 0 || exp_sp.size() != 0) && waited < 3000) begin
      idle(1);
      waited++;
    end
    if (exp_wr.size() != 0 || exp_sp.size() != 0) begin
      errors++;
      $display("Timeout with %0d write and %0d other packets still expected",
               exp_wr.size(), exp_sp.size());
    end
    idle(20);
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_pkt(input rdma_pkg::pkt_req_t got, input rdma_pkg::pkt_req_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: pkt_data = %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Output monitor, sorts each packet to its engine class
  always @(posedge aclk) begin
    if (aresetn && pkt_valid && pkt_ready) begin
      npkt++;
      if (!pkt_data.mode && pkt_data.opcode inside {rdma_pkg::RC_RDMA_WRITE_FIRST,
          rdma_pkg::RC_RDMA_WRITE_MIDDLE, rdma_pkg::RC_RDMA_WRITE_LAST,
          rdma_pkg::RC_RDMA_WRITE_ONLY}) begin
        if (exp_wr.size() == 0) begin
          errors++;
          $display("Write packet at %0t ns when none was expected", $time);
        end else begin
          check_pkt(pkt_data, exp_wr.pop_front());
        end
      end else if (exp_sp.size() == 0) begin
        errors++;
        $display("Single packet at %0t ns when none was expected", $time);
      end else begin
        check_pkt(pkt_data, exp_sp.pop_front());
      end
    end
    if (aresetn && used > rdma_pkg::QUEUE_DEPTH) begin
      errors++;
      $display("Input queue level %0d above its depth at %0t ns", used, $time);
    end
  end

  // Output back-pressure, picked at the edge and driven 2 ns later
  always @(posedge aclk) begin
    if (rdy_mode == 0) begin
      rdy_next = 1'b1;
    end else begin
      rdy_cyc++;
      rdy_next = (rdy_cyc >= 400 && rdy_cyc < 600) ? 1'b0 : (rand_bits(2) != 0);
    end
    #2;
    pkt_ready = rdy_next;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int             e0;
    rdma_pkg::len_t wr_lens [6];
    aclk      = 1'b0;
    aresetn   = 1'b0;
    req_valid = 1'b0;
    req_data  = '0;
    pkt_ready = 1'b0;
    errors    = 0;
    npkt      = 0;
    rdy_mode  = 0;
    rdy_cyc   = 0;
    wr_lens   = '{32'd1, 32'd1023, 32'd1024, 32'd1025, 32'd2048, 32'd3500};
    repeat (5) @(posedge aclk);
    #2;
    aresetn = 1'b1;

    e0 = errors;
    check_flag("pkt_valid", pkt_valid, 1'b0);
    check_flag("req_ready", req_ready, 1'b1);
    check_count("used", used, 32'd0);
    end_test("test 1 reset state", e0);

    e0 = errors;
    send_req(make_req(rdma_pkg::APP_READ, 1'b0, 32'd64));
    send_req(make_req(rdma_pkg::APP_SEND, 1'b0, 32'd2000));
    send_req(make_req(rdma_pkg::APP_IMMED, 1'b0, 32'd8));
    wait_drain();
    end_test("test 2 read, send, immediate", e0);

    e0 = errors;
    foreach (wr_lens[i]) send_req(make_req(rdma_pkg::APP_WRITE, 1'b0, wr_lens[i]));
    wait_drain();
    end_test("test 3 write segmentation", e0);

    e0 = errors;
    repeat (4) send_req(make_req(5'(rand_bits(5)), 1'b1, 32'd300));
    send_req(make_req(5'd0, 1'b0, 32'd16));   // Unknown opcodes
    send_req(make_req(5'd9, 1'b0, 32'd16));
    send_req(make_req(5'd31, 1'b0, 32'd16));
    wait_drain();
    end_test("test 4 raw and dropped requests", e0);

    e0       = errors;
    rdy_mode = 1;
    repeat (300) begin
      send_req(rand_req());
      idle(rand_bits(2));
    end
    wait_drain();
    rdy_mode = 0;
    end_test("test 5 random mix under back-pressure", e0);

    $display("%0d packets checked, %0d errors", npkt, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
